// File: design/mem_pkg.sv
// memory geometry package with lane, word, index and byte address widths of the DLM
package mem_pkg;

	// bits in one byte lane
	localparam int BYTE_BITS = 8;

	// byte lanes per memory word
	localparam int DLM_BYTES = 4;

	// width of one memory word
	localparam int DLM_WORD_BITS = DLM_BYTES * BYTE_BITS;

	// word index width, 256 words deep
	localparam int DLM_INDEX_BITS = 8;

	// byte address = word index plus two lane offset bits
	localparam int DLM_ADDR_BITS = DLM_INDEX_BITS + 2;

endpackage

// File: design/lsu_pkg.sv
// load/store access package with the access size encoding and the byte offset width
package lsu_pkg;

	// access size of a load/store request
	// encoding 2'd3 is unused and decodes as misaligned
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} access_size_t;

	// low address bits that pick a byte within a word
	localparam int OFFSET_BITS = 2;

endpackage

// File: design/ram_bwe.sv
// single-port synchronous RAM with per-byte write enables and a held read address
`timescale 1ns/1ns

module ram_bwe import mem_pkg::*; #(
	parameter int ADDR_WIDTH = DLM_INDEX_BITS,
	parameter int BYTES      = DLM_BYTES
) (
	input  logic                          clk,
	input  logic                          cs,
	input  logic [BYTES-1:0]              bwe,
	input  logic [ADDR_WIDTH-1:0]         addr,
	input  logic [BYTES*BYTE_BITS-1:0]    din,
	output logic [BYTES*BYTE_BITS-1:0]    dout
);

	// storage array, contents are not reset
	logic [BYTES*BYTE_BITS-1:0] mem [(1<<ADDR_WIDTH)-1:0];

	// address captured by the last chip-selected read
	logic [ADDR_WIDTH-1:0] rd_addr;

	// write path
	// only the enabled lanes of din land in the addressed word
	always_ff @(posedge clk) begin
		if (cs) begin
			for (int i = 0; i < BYTES; i++) begin
				if (bwe[i]) begin
					mem[addr][i*BYTE_BITS +: BYTE_BITS] <= din[i*BYTE_BITS +: BYTE_BITS];
				end
			end
		end
	end

	// read path
	// a select with no byte enables is a read, so the address is latched
	always_ff @(posedge clk) begin
		if (cs && (bwe == '0)) begin
			rd_addr <= addr;
		end
	end

	// word at the held address
	// stays put until the next read unless that word is written
	assign dout = mem[rd_addr];

endmodule

// File: design/access_decode.sv
// request decoder: alignment check, word index, byte enables and lane placed store data
`timescale 1ns/1ns

module access_decode import mem_pkg::*, lsu_pkg::*; (
	input  logic                      req,
	input  logic                      we,
	input  access_size_t              size,
	input  logic [DLM_ADDR_BITS-1:0]  addr,
	input  logic [DLM_WORD_BITS-1:0]  wdata,
	output logic                      cs,
	output logic                      acc_ok,
	output logic [DLM_BYTES-1:0]      bwe,
	output logic [DLM_INDEX_BITS-1:0] index,
	output logic [OFFSET_BITS-1:0]    offset,
	output logic [DLM_WORD_BITS-1:0]  din
);

	// lane mask before shifting to the offset
	logic [DLM_BYTES-1:0] base_mask;

	// split the byte address
	assign offset = addr[OFFSET_BITS-1:0];
	assign index  = addr[DLM_ADDR_BITS-1:OFFSET_BITS];

	// alignment rules
	// bytes always pass, halfwords need bit 0 clear, words need both clear
	always_comb begin
		case (size)
			SIZE_BYTE: acc_ok = 1'b1;
			SIZE_HALF: acc_ok = ~offset[0];
			SIZE_WORD: acc_ok = (offset == '0);
			default:   acc_ok = 1'b0;
		endcase
	end

	// misaligned requests never reach the RAM
	assign cs = req & acc_ok;

	// lanes touched by the access, starting at lane 0
	always_comb begin
		case (size)
			SIZE_BYTE: base_mask = 4'b0001;
			SIZE_HALF: base_mask = 4'b0011;
			default:   base_mask = 4'b1111;
		endcase
	end

	// enables only for a selected store
	// a load leaves them all clear
	assign bwe = (cs & we) ? (base_mask << offset) : '0;

	// store data replicated across the word
	// any aligned lane then already holds the right bytes
	always_comb begin
		case (size)
			SIZE_BYTE: din = {DLM_BYTES{wdata[BYTE_BITS-1:0]}};
			SIZE_HALF: din = {(DLM_BYTES/2){wdata[2*BYTE_BITS-1:0]}};
			default:   din = wdata;
		endcase
	end

endmodule

// File: design/load_extract.sv
// load extractor: response strobe, error flag and zero or sign extended load data
`timescale 1ns/1ns

module load_extract import mem_pkg::*, lsu_pkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     req,
	input  logic                     we,
	input  access_size_t             size,
	input  logic                     sign_ext,
	input  logic                     acc_ok,
	input  logic [OFFSET_BITS-1:0]   offset,
	input  logic [DLM_WORD_BITS-1:0] dout,
	output logic                     rsp_valid,
	output logic                     err,
	output logic [DLM_WORD_BITS-1:0] rdata
);

	// request attributes held for the response cycle
	logic                   load_q;
	access_size_t           size_q;
	logic                   sign_q;
	logic [OFFSET_BITS-1:0] offset_q;

	// addressed lanes moved down to bit 0
	logic [DLM_WORD_BITS-1:0] shifted;
	logic [DLM_WORD_BITS-1:0] extended;

	// one response per request, one cycle later
	always_ff @(posedge clk) begin
		if (reset) begin
			rsp_valid <= 1'b0;
			err       <= 1'b0;
		end else begin
			rsp_valid <= req;
			err       <= req & ~acc_ok;
		end
	end

	always_ff @(posedge clk) begin
		if (req) begin
			load_q   <= ~we;
			size_q   <= size;
			sign_q   <= sign_ext;
			offset_q <= offset;
		end
	end

	assign shifted = dout >> (offset_q * BYTE_BITS);

	// keep 8, 16 or 32 bits and fill above with zeros or the top kept bit
	always_comb begin
		case (size_q)
			SIZE_BYTE: extended = {{(DLM_WORD_BITS-BYTE_BITS){sign_q & shifted[BYTE_BITS-1]}},
				shifted[BYTE_BITS-1:0]};
			SIZE_HALF: extended = {{(DLM_WORD_BITS-2*BYTE_BITS){sign_q & shifted[2*BYTE_BITS-1]}},
				shifted[2*BYTE_BITS-1:0]};
			default:   extended = shifted;
		endcase
	end

	// zero for stores, errors and idle cycles
	assign rdata = (rsp_valid & load_q & ~err) ? extended : '0;

endmodule

// File: design/dlm_top.sv
// data local memory top: request decoder, byte-write RAM and load extractor
`timescale 1ns/1ns

module dlm_top import mem_pkg::*, lsu_pkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     req,
	input  logic                     we,
	input  access_size_t             size,
	input  logic                     sign_ext,
	input  logic [DLM_ADDR_BITS-1:0] addr,
	input  logic [DLM_WORD_BITS-1:0] wdata,
	output logic                     rsp_valid,
	output logic [DLM_WORD_BITS-1:0] rdata,
	output logic                     err
);

	// decoder to RAM
	logic                      cs;
	logic [DLM_BYTES-1:0]      bwe;
	logic [DLM_INDEX_BITS-1:0] index;
	logic [DLM_WORD_BITS-1:0]  din;

	// decoder and RAM to extractor
	logic                      acc_ok;
	logic [OFFSET_BITS-1:0]    offset;
	logic [DLM_WORD_BITS-1:0]  dout;

	access_decode decode_i (
		.req    (req),
		.we     (we),
		.size   (size),
		.addr   (addr),
		.wdata  (wdata),
		.cs     (cs),
		.acc_ok (acc_ok),
		.bwe    (bwe),
		.index  (index),
		.offset (offset),
		.din    (din)
	);

	ram_bwe #(
		.ADDR_WIDTH (DLM_INDEX_BITS),
		.BYTES      (DLM_BYTES)
	) ram_i (
		.clk  (clk),
		.cs   (cs),
		.bwe  (bwe),
		.addr (index),
		.din  (din),
		.dout (dout)
	);

	load_extract extract_i (
		.clk       (clk),
		.reset     (reset),
		.req       (req),
		.we        (we),
		.size      (size),
		.sign_ext  (sign_ext),
		.acc_ok    (acc_ok),
		.offset    (offset),
		.dout      (dout),
		.rsp_valid (rsp_valid),
		.err       (err),
		.rdata     (rdata)
	);

endmodule

// File: tests/dlm_tb.sv
// directed testbench for the data local memory with a shadow byte model of the RAM
`timescale 1ns/1ns

module dlm_tb import mem_pkg::*, lsu_pkg::*; ();

	localparam int unsigned RAND_SEED = 32'h87d97da5;
	// tests take about 700 cycles
	localparam int TIMEOUT_CYCLES = 3000;
	localparam logic [DLM_ADDR_BITS-1:0] BURST_BASE = 10'h100;
	localparam int BURST_WORDS = 16;
	localparam int BURST_COUNT = 400;

	logic                     clk;
	logic                     reset;
	logic                     req;
	logic                     we;
	access_size_t             size;
	logic                     sign_ext;
	logic [DLM_ADDR_BITS-1:0] addr;
	logic [DLM_WORD_BITS-1:0] wdata;
	logic                     rsp_valid;
	logic [DLM_WORD_BITS-1:0] rdata;
	logic                     err;

	// shadow of the memory, one entry per byte address
	logic [BYTE_BITS-1:0] shadow [0:(1<<DLM_ADDR_BITS)-1];
	// set once a full word store has initialised the word
	logic written [0:(1<<DLM_INDEX_BITS)-1] = '{default: 1'b0};

	// response expected in the current cycle
	logic                     pend_valid;
	logic                     pend_err;
	logic [DLM_WORD_BITS-1:0] pend_rdata;
	string                    pend_desc;

	int cycle_count = 0;

	dlm_top dlm_top_i (
		.clk       (clk),
		.reset     (reset),
		.req       (req),
		.we        (we),
		.size      (size),
		.sign_ext  (sign_ext),
		.addr      (addr),
		.wdata     (wdata),
		.rsp_valid (rsp_valid),
		.rdata     (rdata),
		.err       (err)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			stop_run();
		end
	end

	task automatic stop_run();
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic value_error(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		stop_run();
	endtask

	function automatic int access_bytes(access_size_t sz);
		case (sz)
			SIZE_BYTE: return 1;
			SIZE_HALF: return 2;
			default:   return DLM_BYTES;
		endcase
	endfunction

	// halfwords on even addresses, words on multiples of four
	function automatic logic is_aligned(access_size_t sz, logic [DLM_ADDR_BITS-1:0] a);
		case (sz)
			SIZE_BYTE: return 1'b1;
			SIZE_HALF: return (a[0] == 1'b0);
			SIZE_WORD: return (a[1:0] == 2'b00);
			default:   return 1'b0;
		endcase
	endfunction

	function automatic void write_shadow(access_size_t sz, logic [DLM_ADDR_BITS-1:0] a,
			logic [DLM_WORD_BITS-1:0] d);
		int n;
		n = access_bytes(sz);
		for (int k = 0; k < n; k++) begin
			shadow[a + DLM_ADDR_BITS'(k)] = d[BYTE_BITS*k +: BYTE_BITS];
		end
		if (sz == SIZE_WORD) begin
			written[a[DLM_ADDR_BITS-1:OFFSET_BITS]] = 1'b1;
		end
	endfunction

	// little endian bytes from the shadow, then zero or sign fill
	function automatic logic [DLM_WORD_BITS-1:0] expected_load(access_size_t sz, logic sx,
			logic [DLM_ADDR_BITS-1:0] a);
		logic [DLM_WORD_BITS-1:0] value;
		logic [BYTE_BITS-1:0]     top;
		int                       n;
		n = access_bytes(sz);
		value = '0;
		for (int k = 0; k < n; k++) begin
			value[BYTE_BITS*k +: BYTE_BITS] = shadow[a + DLM_ADDR_BITS'(k)];
		end
		// most significant byte read gives the sign
		top = shadow[a + DLM_ADDR_BITS'(n - 1)];
		if (sx && top[BYTE_BITS-1]) begin
			for (int k = n; k < DLM_BYTES; k++) begin
				value[BYTE_BITS*k +: BYTE_BITS] = 8'hff;
			end
		end
		return value;
	endfunction

	// compare the outputs of this cycle with the pending response
	task automatic check_response();
		if (pend_valid) begin
			assert (rsp_valid === 1'b1)
				else value_error($sformatf("%s: rsp_valid low one cycle after req", pend_desc));
			assert (err === pend_err)
				else value_error($sformatf("%s: err %b, expected %b", pend_desc, err, pend_err));
			assert (rdata === pend_rdata)
				else value_error($sformatf("%s: rdata 0x%08h, expected 0x%08h",
					pend_desc, rdata, pend_rdata));
		end else begin
			assert (rsp_valid === 1'b0)
				else value_error("rsp_valid high without a request in the previous cycle");
			assert (err === 1'b0)
				else value_error("err high without a response");
		end
	endtask

	// one request on the falling edge, response checked on the next one
	task automatic issue_request(input logic w, input access_size_t sz, input logic sx,
			input logic [DLM_ADDR_BITS-1:0] a, input logic [DLM_WORD_BITS-1:0] d);
		logic  ok;
		string kind;
		@(negedge clk);
		check_response();
		req      = 1'b1;
		we       = w;
		size     = sz;
		sign_ext = sx;
		addr     = a;
		wdata    = d;
		ok = is_aligned(sz, a);
		if (w) begin
			kind = "store";
		end else begin
			kind = "load";
		end
		pend_valid = 1'b1;
		pend_err   = ~ok;
		pend_rdata = '0;
		pend_desc  = $sformatf("%s %s at 0x%03h", kind, sz.name(), a);
		if (ok && w) begin
			write_shadow(sz, a, d);
		end else if (ok) begin
			assert (written[a[DLM_ADDR_BITS-1:OFFSET_BITS]] === 1'b1) else begin
				$display("Test problem: a load at 0x%03h reads a word that was never written", a);
				stop_run();
			end
			pend_rdata = expected_load(sz, sx, a);
		end
	endtask

	task automatic idle_cycle();
		@(negedge clk);
		check_response();
		req        = 1'b0;
		we         = 1'b0;
		pend_valid = 1'b0;
	endtask

	task automatic do_store(input logic [DLM_ADDR_BITS-1:0] a, input access_size_t sz,
			input logic [DLM_WORD_BITS-1:0] d);
		issue_request(1'b1, sz, 1'b0, a, d);
		idle_cycle();
	endtask

	task automatic do_load(input logic [DLM_ADDR_BITS-1:0] a, input access_size_t sz,
			input logic sx);
		issue_request(1'b0, sz, sx, a, '0);
		idle_cycle();
	endtask

	task automatic test_reset_idle();
		repeat (8) idle_cycle();
	endtask

	task automatic test_word_access();
		logic [DLM_ADDR_BITS-1:0] addrs [6];
		addrs = '{10'h000, 10'h004, 10'h3fc, 10'h1a8, 10'h2f0, 10'h060};
		for (int i = 0; i < 6; i++) begin
			do_store(addrs[i], SIZE_WORD, $urandom);
		end
		for (int i = 0; i < 6; i++) begin
			do_load(addrs[i], SIZE_WORD, 1'b0);
		end
	endtask

	task automatic test_lane_merge();
		do_store(10'h050, SIZE_WORD, 32'h11223344);
		// upper bits of wdata must not leak into other lanes
		do_store(10'h051, SIZE_BYTE, 32'hdeadbea5);
		do_load(10'h050, SIZE_WORD, 1'b0);
		do_store(10'h052, SIZE_HALF, 32'h9876c3d2);
		do_load(10'h050, SIZE_WORD, 1'b0);
		do_store(10'h054, SIZE_WORD, 32'hcafef00d);
		do_store(10'h057, SIZE_BYTE, 32'h00000071);
		do_store(10'h054, SIZE_HALF, 32'hffff8e8e);
		do_load(10'h054, SIZE_WORD, 1'b0);
		// hand merged words
		assert (expected_load(SIZE_WORD, 1'b0, 10'h050) === 32'hc3d2a544)
			else value_error("shadow word at 0x050 differs from 0xc3d2a544");
		assert (expected_load(SIZE_WORD, 1'b0, 10'h054) === 32'h71fe8e8e)
			else value_error("shadow word at 0x054 differs from 0x71fe8e8e");
	endtask

	task automatic test_narrow_loads();
		logic [DLM_ADDR_BITS-1:0] base;
		// bytes and halves with and without the top bit set
		do_store(10'h040, SIZE_WORD, 32'hf07f8001);
		do_store(10'h044, SIZE_WORD, 32'h7ffe12c3);
		for (int wi = 0; wi < 2; wi++) begin
			base = 10'h040 + DLM_ADDR_BITS'(4 * wi);
			for (int s = 0; s < 2; s++) begin
				for (int off = 0; off < DLM_BYTES; off++) begin
					do_load(base + DLM_ADDR_BITS'(off), SIZE_BYTE, s[0]);
				end
				do_load(base, SIZE_HALF, s[0]);
				do_load(base + 10'd2, SIZE_HALF, s[0]);
				do_load(base, SIZE_WORD, s[0]);
			end
		end
	endtask

	task automatic test_misaligned();
		do_store(10'h080, SIZE_WORD, 32'h5aa5c33c);
		for (int off = 1; off < DLM_BYTES; off++) begin
			do_store(10'h080 + DLM_ADDR_BITS'(off), SIZE_WORD, 32'hffffffff);
			do_load(10'h080 + DLM_ADDR_BITS'(off), SIZE_WORD, 1'b1);
		end
		do_store(10'h081, SIZE_HALF, 32'h0000ffff);
		do_store(10'h083, SIZE_HALF, 32'h0000ffff);
		do_load(10'h081, SIZE_HALF, 1'b1);
		do_load(10'h083, SIZE_HALF, 1'b0);
		// word must still hold its first value
		do_load(10'h080, SIZE_WORD, 1'b0);
	endtask

	task automatic test_random_burst();
		int unsigned              r;
		int unsigned              sel;
		logic [DLM_ADDR_BITS-1:0] a;
		access_size_t             sz;
		// initialise the block on consecutive cycles
		for (int i = 0; i < BURST_WORDS; i++) begin
			issue_request(1'b1, SIZE_WORD, 1'b0, BURST_BASE + DLM_ADDR_BITS'(4 * i), $urandom);
		end
		for (int i = 0; i < BURST_COUNT; i++) begin
			r = $urandom;
			sel = $urandom_range(2, 0);
			sz = access_size_t'(sel[1:0]);
			a = BURST_BASE + DLM_ADDR_BITS'(r[5:0]);
			issue_request(r[6], sz, r[7], a, $urandom);
			// sometimes read back the stored address on the very next cycle
			if (r[6] && (r[9:8] == 2'b00)) begin
				issue_request(1'b0, sz, r[10], a, '0);
			end
		end
		idle_cycle();
	endtask

	initial begin
		void'($urandom(RAND_SEED));
		reset      = 1'b1;
		// a misaligned load held through reset must leave no response behind
		req        = 1'b1;
		we         = 1'b0;
		size       = SIZE_WORD;
		sign_ext   = 1'b0;
		addr       = 10'h001;
		wdata      = '0;
		pend_valid = 1'b0;
		pend_err   = 1'b0;
		pend_rdata = '0;
		pend_desc  = "";
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_response();
		reset = 1'b0;
		req   = 1'b0;

		test_reset_idle();
		test_word_access();
		test_lane_merge();
		test_narrow_loads();
		test_misaligned();
		test_random_burst();

		$display("Testbench passed");
		$finish;
	end

endmodule

// File: list.f
design/mem_pkg.sv
design/lsu_pkg.sv
design/ram_bwe.sv
design/access_decode.sv
design/load_extract.sv
design/dlm_top.sv
tests/dlm_tb.sv

// File: run.sh
#!/bin/sh
# build the DLM testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module dlm_tb -f list.f -o dlm_sim || { echo "build failed"; exit 1; }
out=$(./obj_dir/dlm_sim)
echo "$out"
echo "$out" | grep -q "Testbench passed" && echo "PASS" || { echo "FAIL"; exit 1; }
